//--- include/id_stage_config.svh
`ifndef ID_STAGE_CONFIG_SVH
`define ID_STAGE_CONFIG_SVH

// Data path and register file geometry.
`define ID_WORD_WIDTH 32
`define ID_REG_ADDR_WIDTH 5
`define ID_REG_COUNT 32

// Widths of the decoded operator and category fields.
`define ID_OPERATOR_WIDTH 8
`define ID_CATEGORY_WIDTH 3

`endif

//--- hdl/isa_pkg.sv
`default_nettype none

`include "id_stage_config.svh"

package isa_pkg;

    typedef logic [`ID_WORD_WIDTH-1:0] word_t;
    typedef logic [`ID_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Primary opcode in bits 31:26 of the instruction word.
    typedef enum logic [5:0] {
        opcode_special = 6'h00,
        opcode_addi    = 6'h08,
        opcode_addiu   = 6'h09,
        opcode_slti    = 6'h0A,
        opcode_sltiu   = 6'h0B,
        opcode_andi    = 6'h0C,
        opcode_ori     = 6'h0D,
        opcode_xori    = 6'h0E,
        opcode_lui     = 6'h0F
    } opcode_e;

    // Function code in bits 5:0, valid under the special opcode.
    typedef enum logic [5:0] {
        funct_sll  = 6'h00,
        funct_srl  = 6'h02,
        funct_sra  = 6'h03,
        funct_sllv = 6'h04,
        funct_srlv = 6'h06,
        funct_srav = 6'h07,
        funct_add  = 6'h20,
        funct_addu = 6'h21,
        funct_sub  = 6'h22,
        funct_subu = 6'h23,
        funct_and  = 6'h24,
        funct_or   = 6'h25,
        funct_xor  = 6'h26,
        funct_nor  = 6'h27,
        funct_slt  = 6'h2A,
        funct_sltu = 6'h2B
    } funct_e;

endpackage

`default_nettype wire

//--- hdl/id_pkg.sv
`default_nettype none

`include "id_stage_config.svh"

package id_pkg;

    // Operation handed to the execute stage.
    typedef enum logic [`ID_OPERATOR_WIDTH-1:0] {
        operator_nop  = 8'd0,
        operator_and  = 8'd1,
        operator_or   = 8'd2,
        operator_xor  = 8'd3,
        operator_nor  = 8'd4,
        operator_sll  = 8'd5,
        operator_srl  = 8'd6,
        operator_sra  = 8'd7,
        operator_slt  = 8'd8,
        operator_sltu = 8'd9,
        operator_add  = 8'd10,
        operator_addu = 8'd11,
        operator_sub  = 8'd12,
        operator_subu = 8'd13
    } operator_e;

    typedef enum logic [`ID_CATEGORY_WIDTH-1:0] {
        category_none       = 3'd0,
        category_logic      = 3'd1,
        category_shift      = 3'd2,
        category_arithmetic = 3'd3
    } category_e;

endpackage

`default_nettype wire

//--- hdl/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    id_pkg::operator_e  operator;
    id_pkg::category_e  category;
    logic               read_enable_a;
    isa_pkg::reg_addr_t read_address_a;
    logic               read_enable_b;
    isa_pkg::reg_addr_t read_address_b;
    logic               write_enable;
    isa_pkg::reg_addr_t write_address;
    isa_pkg::word_t     immediate;
    logic               invalid;

    modport decoder (
        output operator, category, read_enable_a, read_address_a, read_enable_b,
        output read_address_b, write_enable, write_address, immediate, invalid
    );

    modport reader (input read_address_a, read_address_b);

    modport consumer (
        input operator, category, read_enable_a, read_address_a, read_enable_b,
        input read_address_b, write_enable, write_address, immediate, invalid
    );

endinterface

`default_nettype wire

//--- hdl/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
    input  isa_pkg::word_t instruction,
    decode_if.decoder      dec
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::reg_addr_t rd;
    logic [4:0]         shamt;
    logic [15:0]        imm16;

    id_pkg::operator_e  op;
    id_pkg::category_e  cat;
    logic               form_register;
    logic               form_immediate;
    logic               form_shift_amount;
    logic               imm_signed;
    logic               imm_upper;
    logic               recognized;

    assign opcode = isa_pkg::opcode_e'(instruction[31:26]);
    assign funct  = isa_pkg::funct_e'(instruction[5:0]);
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign shamt  = instruction[10:6];
    assign imm16  = instruction[15:0];

    // Classify the word into an operation and one of three encoding forms.
    always_comb begin
        op                = id_pkg::operator_nop;
        cat               = id_pkg::category_none;
        form_register     = 1'b0;
        form_immediate    = 1'b0;
        form_shift_amount = 1'b0;
        imm_signed        = 1'b0;
        imm_upper         = 1'b0;

        case (opcode)
            isa_pkg::opcode_special: begin
                // Register forms need a zero shamt; immediate shifts need a zero rs.
                form_register = (shamt == 5'd0);
                case (funct)
                    isa_pkg::funct_and:  {op, cat} = {id_pkg::operator_and, id_pkg::category_logic};
                    isa_pkg::funct_or:   {op, cat} = {id_pkg::operator_or, id_pkg::category_logic};
                    isa_pkg::funct_xor:  {op, cat} = {id_pkg::operator_xor, id_pkg::category_logic};
                    isa_pkg::funct_nor:  {op, cat} = {id_pkg::operator_nor, id_pkg::category_logic};
                    isa_pkg::funct_sllv: {op, cat} = {id_pkg::operator_sll, id_pkg::category_shift};
                    isa_pkg::funct_srlv: {op, cat} = {id_pkg::operator_srl, id_pkg::category_shift};
                    isa_pkg::funct_srav: {op, cat} = {id_pkg::operator_sra, id_pkg::category_shift};
                    isa_pkg::funct_add:  {op, cat} = {id_pkg::operator_add, id_pkg::category_arithmetic};
                    isa_pkg::funct_addu: {op, cat} = {id_pkg::operator_addu, id_pkg::category_arithmetic};
                    isa_pkg::funct_sub:  {op, cat} = {id_pkg::operator_sub, id_pkg::category_arithmetic};
                    isa_pkg::funct_subu: {op, cat} = {id_pkg::operator_subu, id_pkg::category_arithmetic};
                    isa_pkg::funct_slt:  {op, cat} = {id_pkg::operator_slt, id_pkg::category_arithmetic};
                    isa_pkg::funct_sltu: {op, cat} = {id_pkg::operator_sltu, id_pkg::category_arithmetic};
                    isa_pkg::funct_sll, isa_pkg::funct_srl, isa_pkg::funct_sra: begin
                        form_register     = 1'b0;
                        form_shift_amount = (rs == '0);
                        cat               = id_pkg::category_shift;
                        op = (funct == isa_pkg::funct_sll) ? id_pkg::operator_sll :
                             (funct == isa_pkg::funct_srl) ? id_pkg::operator_srl :
                                                             id_pkg::operator_sra;
                    end
                    default: form_register = 1'b0;
                endcase
            end
            isa_pkg::opcode_andi: {op, cat} = {id_pkg::operator_and, id_pkg::category_logic};
            isa_pkg::opcode_ori:  {op, cat} = {id_pkg::operator_or, id_pkg::category_logic};
            isa_pkg::opcode_xori: {op, cat} = {id_pkg::operator_xor, id_pkg::category_logic};
            isa_pkg::opcode_lui: begin
                {op, cat} = {id_pkg::operator_or, id_pkg::category_logic};
                imm_upper = 1'b1;
            end
            isa_pkg::opcode_addi:  {op, cat} = {id_pkg::operator_add, id_pkg::category_arithmetic};
            isa_pkg::opcode_addiu: {op, cat} = {id_pkg::operator_addu, id_pkg::category_arithmetic};
            isa_pkg::opcode_slti:  {op, cat} = {id_pkg::operator_slt, id_pkg::category_arithmetic};
            isa_pkg::opcode_sltiu: {op, cat} = {id_pkg::operator_sltu, id_pkg::category_arithmetic};
            default: ;
        endcase

        if (opcode != isa_pkg::opcode_special && cat != id_pkg::category_none) begin
            form_immediate = 1'b1;
            imm_signed = (cat == id_pkg::category_arithmetic);
        end
    end

    assign recognized = form_register | form_immediate | form_shift_amount;

    always_comb begin
        dec.operator       = recognized ? op : id_pkg::operator_nop;
        dec.category       = recognized ? cat : id_pkg::category_none;
        dec.read_enable_a  = form_register | form_immediate;
        dec.read_address_a = rs;
        dec.read_enable_b  = form_register | form_shift_amount;
        dec.read_address_b = rt;
        dec.write_enable   = recognized;
        dec.write_address  = form_immediate ? rt : rd;
        dec.invalid        = ~recognized;

        if (form_immediate && imm_upper) begin
            dec.immediate = {imm16, 16'h0000};
        end else if (form_immediate && imm_signed) begin
            dec.immediate = {{16{imm16[15]}}, imm16};
        end else if (form_immediate) begin
            dec.immediate = isa_pkg::word_t'(imm16);
        end else if (form_shift_amount) begin
            dec.immediate = isa_pkg::word_t'(shamt);
        end else begin
            dec.immediate = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/id_register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_config.svh"

module id_register_file (
    input  logic               clock,
    input  logic               rst_n,
    decode_if.reader           rd,
    input  logic               wb_write_enable,
    input  isa_pkg::reg_addr_t wb_write_address,
    input  isa_pkg::word_t     wb_write_data,
    output isa_pkg::word_t     read_data_a,
    output isa_pkg::word_t     read_data_b
);

    isa_pkg::word_t registers [`ID_REG_COUNT];

    // Register 0 is hardwired, and a same-cycle writeback is seen by the reader.
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t address);
        if (address == '0) begin
            return '0;
        end
        if (wb_write_enable && (wb_write_address == address)) begin
            return wb_write_data;
        end
        return registers[address];
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `ID_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (wb_write_enable && (wb_write_address != '0)) begin
            registers[wb_write_address] <= wb_write_data;
        end
    end

    always_comb begin
        read_data_a = read_port(rd.read_address_a);
        read_data_b = read_port(rd.read_address_b);
    end

    wb_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        wb_write_enable |-> !$isunknown({wb_write_address, wb_write_data})
    ) else $error("writeback with unknown address or data");

endmodule

`default_nettype wire

//--- hdl/id_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_select (
    input  logic               read_enable,
    input  isa_pkg::reg_addr_t read_address,
    input  isa_pkg::word_t     register_data,
    input  isa_pkg::word_t     immediate,
    input  logic               ex_write_enable,
    input  isa_pkg::reg_addr_t ex_write_address,
    input  isa_pkg::word_t     ex_write_data,
    input  logic               mem_write_enable,
    input  isa_pkg::reg_addr_t mem_write_address,
    input  isa_pkg::word_t     mem_write_data,
    output isa_pkg::word_t     operand
);

    logic ex_hit;
    logic mem_hit;

    // The younger ex result takes priority over mem.
    assign ex_hit  = ex_write_enable && (ex_write_address == read_address) && (read_address != '0);
    assign mem_hit = mem_write_enable && (mem_write_address == read_address) && (read_address != '0);

    assign operand = !read_enable ? immediate :
                     ex_hit       ? ex_write_data :
                     mem_hit      ? mem_write_data :
                                    register_data;

endmodule

`default_nettype wire

//--- hdl/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_register (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               in_valid,
    decode_if.consumer         dec,
    input  isa_pkg::word_t     operand_a,
    input  isa_pkg::word_t     operand_b,
    output logic               out_valid,
    output id_pkg::operator_e  operator,
    output id_pkg::category_e  category,
    output isa_pkg::word_t     result_a,
    output isa_pkg::word_t     result_b,
    output logic               write_enable,
    output isa_pkg::reg_addr_t write_address,
    output logic               instruction_invalid
);

    // Fields are captured only on a strobe and held between strobes.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid           <= 1'b0;
            operator            <= id_pkg::operator_nop;
            category            <= id_pkg::category_none;
            result_a            <= '0;
            result_b            <= '0;
            write_enable        <= 1'b0;
            write_address       <= '0;
            instruction_invalid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                operator            <= dec.operator;
                category            <= dec.category;
                result_a            <= operand_a;
                result_b            <= operand_b;
                write_enable        <= dec.write_enable;
                write_address       <= dec.write_address;
                instruction_invalid <= dec.invalid;
            end
        end
    end

    no_write_when_invalid: assert property (
        @(posedge clock) disable iff (!rst_n) !(write_enable && instruction_invalid)
    ) else $error("write enabled for an invalid instruction");

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               in_valid,
    input  isa_pkg::word_t     instruction,
    input  logic               wb_write_enable,
    input  isa_pkg::reg_addr_t wb_write_address,
    input  isa_pkg::word_t     wb_write_data,
    input  logic               ex_write_enable,
    input  isa_pkg::reg_addr_t ex_write_address,
    input  isa_pkg::word_t     ex_write_data,
    input  logic               mem_write_enable,
    input  isa_pkg::reg_addr_t mem_write_address,
    input  isa_pkg::word_t     mem_write_data,
    output logic               out_valid,
    output id_pkg::operator_e  operator,
    output id_pkg::category_e  category,
    output isa_pkg::word_t     operand_a,
    output isa_pkg::word_t     operand_b,
    output logic               write_enable,
    output isa_pkg::reg_addr_t write_address,
    output logic               instruction_invalid
);

    isa_pkg::word_t register_data_a;
    isa_pkg::word_t register_data_b;
    isa_pkg::word_t selected_a;
    isa_pkg::word_t selected_b;

    decode_if dec_bus ();

    id_decoder u_decoder (
        .instruction (instruction),
        .dec         (dec_bus.decoder)
    );

    id_register_file u_register_file (
        .clock            (clock),
        .rst_n            (rst_n),
        .rd               (dec_bus.reader),
        .wb_write_enable  (wb_write_enable),
        .wb_write_address (wb_write_address),
        .wb_write_data    (wb_write_data),
        .read_data_a      (register_data_a),
        .read_data_b      (register_data_b)
    );

    id_operand_select u_operand_a (
        .read_enable       (dec_bus.read_enable_a),
        .read_address      (dec_bus.read_address_a),
        .register_data     (register_data_a),
        .immediate         (dec_bus.immediate),
        .ex_write_enable   (ex_write_enable),
        .ex_write_address  (ex_write_address),
        .ex_write_data     (ex_write_data),
        .mem_write_enable  (mem_write_enable),
        .mem_write_address (mem_write_address),
        .mem_write_data    (mem_write_data),
        .operand           (selected_a)
    );

    id_operand_select u_operand_b (
        .read_enable       (dec_bus.read_enable_b),
        .read_address      (dec_bus.read_address_b),
        .register_data     (register_data_b),
        .immediate         (dec_bus.immediate),
        .ex_write_enable   (ex_write_enable),
        .ex_write_address  (ex_write_address),
        .ex_write_data     (ex_write_data),
        .mem_write_enable  (mem_write_enable),
        .mem_write_address (mem_write_address),
        .mem_write_data    (mem_write_data),
        .operand           (selected_b)
    );

    id_ex_register u_id_ex_register (
        .clock               (clock),
        .rst_n               (rst_n),
        .in_valid            (in_valid),
        .dec                 (dec_bus.consumer),
        .operand_a           (selected_a),
        .operand_b           (selected_b),
        .out_valid           (out_valid),
        .operator            (operator),
        .category            (category),
        .result_a            (operand_a),
        .result_b            (operand_b),
        .write_enable        (write_enable),
        .write_address       (write_address),
        .instruction_invalid (instruction_invalid)
    );

endmodule

`default_nettype wire

//--- dv/id_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module id_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clock
);

    // The first rising edge comes half a period after time zero.
    initial begin
        clock = 1'b0;
        forever begin
            #(period_ns / 2) clock = ~clock;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    localparam int stimulus_depth = 1024;
    localparam int preload_words  = 3;
    localparam int decode_words   = 18;

    logic               clock;
    logic               rst_n;
    logic               in_valid;
    isa_pkg::word_t     instruction;
    logic               wb_write_enable;
    isa_pkg::reg_addr_t wb_write_address;
    isa_pkg::word_t     wb_write_data;
    logic               ex_write_enable;
    isa_pkg::reg_addr_t ex_write_address;
    isa_pkg::word_t     ex_write_data;
    logic               mem_write_enable;
    isa_pkg::reg_addr_t mem_write_address;
    isa_pkg::word_t     mem_write_data;
    logic               out_valid;
    id_pkg::operator_e  operator;
    id_pkg::category_e  category;
    isa_pkg::word_t     operand_a;
    isa_pkg::word_t     operand_b;
    logic               write_enable;
    isa_pkg::reg_addr_t write_address;
    logic               instruction_invalid;

    isa_pkg::word_t     stimulus [0:stimulus_depth-1];
    int                 record_count;
    int                 cycle_count = 0;
    int                 cycle_limit = 0;

    logic [7:0]         expected_operator;
    logic [2:0]         expected_category;
    isa_pkg::word_t     expected_a;
    isa_pkg::word_t     expected_b;
    logic               expected_write_enable;
    isa_pkg::reg_addr_t expected_write_address;
    logic               expected_invalid;

    id_clock_gen u_clock_gen (
        .clock (clock)
    );

    id_stage u_id_stage (
        .clock               (clock),
        .rst_n               (rst_n),
        .in_valid            (in_valid),
        .instruction         (instruction),
        .wb_write_enable     (wb_write_enable),
        .wb_write_address    (wb_write_address),
        .wb_write_data       (wb_write_data),
        .ex_write_enable     (ex_write_enable),
        .ex_write_address    (ex_write_address),
        .ex_write_data       (ex_write_data),
        .mem_write_enable    (mem_write_enable),
        .mem_write_address   (mem_write_address),
        .mem_write_data      (mem_write_data),
        .out_valid           (out_valid),
        .operator            (operator),
        .category            (category),
        .operand_a           (operand_a),
        .operand_b           (operand_b),
        .write_enable        (write_enable),
        .write_address       (write_address),
        .instruction_invalid (instruction_invalid)
    );

    // Inputs change and outputs are sampled 2 ns after each rising edge.
    task automatic wait_drive_point();
        @(posedge clock);
        #2;
    endtask

    task automatic report_mismatch(input string field, input isa_pkg::word_t actual,
                                   input isa_pkg::word_t expected);
        $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                 $time, field, actual, expected);
        $display("TEST RESULT: FAIL");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_valid(input logic expected_valid);
        assert (out_valid == expected_valid)
            else report_mismatch("out_valid", 32'(out_valid), 32'(expected_valid));
    endtask

    task automatic check_fields();
        assert (operator == expected_operator)
            else report_mismatch("operator", 32'(operator), 32'(expected_operator));
        assert (category == expected_category)
            else report_mismatch("category", 32'(category), 32'(expected_category));
        assert (operand_a == expected_a)
            else report_mismatch("operand_a", operand_a, expected_a);
        assert (operand_b == expected_b)
            else report_mismatch("operand_b", operand_b, expected_b);
        assert (write_enable == expected_write_enable)
            else report_mismatch("write_enable", 32'(write_enable),
                                 32'(expected_write_enable));
        assert (write_address == expected_write_address)
            else report_mismatch("write_address", 32'(write_address),
                                 32'(expected_write_address));
        assert (instruction_invalid == expected_invalid)
            else report_mismatch("instruction_invalid", 32'(instruction_invalid),
                                 32'(expected_invalid));
    endtask

    // After reset every output of the stage reads as zero.
    task automatic check_reset_values();
        expected_operator      = '0;
        expected_category      = '0;
        expected_a             = '0;
        expected_b             = '0;
        expected_write_enable  = 1'b0;
        expected_write_address = '0;
        expected_invalid       = 1'b0;
        check_valid(1'b0);
        check_fields();
    endtask

    task automatic clear_strobes();
        in_valid         = 1'b0;
        wb_write_enable  = 1'b0;
        ex_write_enable  = 1'b0;
        mem_write_enable = 1'b0;
    endtask

    task automatic drive_preload(input int base);
        wb_write_enable  = 1'b1;
        wb_write_address = stimulus[base + 1][4:0];
        wb_write_data    = stimulus[base + 2];
    endtask

    task automatic drive_decode(input int base);
        in_valid               = 1'b1;
        instruction            = stimulus[base + 1];
        ex_write_enable        = stimulus[base + 2][0];
        ex_write_address       = stimulus[base + 3][4:0];
        ex_write_data          = stimulus[base + 4];
        mem_write_enable       = stimulus[base + 5][0];
        mem_write_address      = stimulus[base + 6][4:0];
        mem_write_data         = stimulus[base + 7];
        wb_write_enable        = stimulus[base + 8][0];
        wb_write_address       = stimulus[base + 9][4:0];
        wb_write_data          = stimulus[base + 10];
        expected_operator      = stimulus[base + 11][7:0];
        expected_category      = stimulus[base + 12][2:0];
        expected_a             = stimulus[base + 13];
        expected_b             = stimulus[base + 14];
        expected_write_enable  = stimulus[base + 15][0];
        expected_write_address = stimulus[base + 16][4:0];
        expected_invalid       = stimulus[base + 17][0];
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int   base;
        int   record;
        logic pending;

        rst_n             = 1'b0;
        in_valid          = 1'b0;
        instruction       = '0;
        wb_write_enable   = 1'b0;
        wb_write_address  = '0;
        wb_write_data     = '0;
        ex_write_enable   = 1'b0;
        ex_write_address  = '0;
        ex_write_data     = '0;
        mem_write_enable  = 1'b0;
        mem_write_address = '0;
        mem_write_data    = '0;

        // Word 0 of the file holds the number of records that follow.
        $readmemh("dv/id_stage_input.txt", stimulus);
        record_count = stimulus[0];
        cycle_limit  = record_count * 4 + 40;

        repeat (10) wait_drive_point();
        rst_n = 1'b1;
        wait_drive_point();
        check_reset_values();

        // Without a strobe the outputs hold the last bundle, which the expected fields still describe.
        base    = 1;
        pending = 1'b0;
        for (record = 0; record < record_count; record++) begin
            wait_drive_point();
            check_valid(pending);
            check_fields();
            clear_strobes();
            if (stimulus[base] == 32'd0) begin
                drive_preload(base);
                base    = base + preload_words;
                pending = 1'b0;
            end else if (stimulus[base] == 32'd1) begin
                drive_decode(base);
                base    = base + decode_words;
                pending = 1'b1;
            end else begin
                $display("Unknown record kind %h at word %0d of the input file",
                         stimulus[base], base);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bad input record");
            end
        end

        wait_drive_point();
        check_valid(pending);
        check_fields();
        clear_strobes();
        wait_drive_point();
        check_valid(1'b0);
        check_fields();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- id_stage.f
+incdir+include
hdl/isa_pkg.sv
hdl/id_pkg.sv
hdl/decode_if.sv
hdl/id_decoder.sv
hdl/id_register_file.sv
hdl/id_operand_select.sv
hdl/id_ex_register.sv
hdl/id_stage.sv
dv/id_clock_gen.sv
dv/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage -f id_stage.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_id_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished with status 0"
exit 0

//--- dv/id_stage_input.txt
// Preload: 0 reg data
// Decode: 1 instr ex_en ex_reg ex_data mem_en mem_reg mem_data wb_en wb_reg wb_data op cat a b we wd inv
00000025
0 01 11111111
0 02 22222222
0 03 80000003
0 04 00000004
0 05 0000ffff
0 06 12345678
0 00 deadbeef
// Register forms: and, nor, sub, sltu, srav, addu with rt = r0.
1 00224024 0 00 00000000 0 00 00000000 0 00 00000000 01 1 11111111 22222222 1 08 0
1 00664827 0 00 00000000 0 00 00000000 0 00 00000000 04 1 80000003 12345678 1 09 0
1 00c45022 0 00 00000000 0 00 00000000 0 00 00000000 0c 3 12345678 00000004 1 0a 0
1 00a3582b 0 00 00000000 0 00 00000000 0 00 00000000 09 3 0000ffff 80000003 1 0b 0
1 00836007 0 00 00000000 0 00 00000000 0 00 00000000 07 2 00000004 80000003 1 0c 0
1 00206821 0 00 00000000 0 00 00000000 0 00 00000000 0b 3 11111111 00000000 1 0d 0
0 07 00000007
// Immediate forms: andi, xori, addi, sltiu, lui, ori.
1 30ce8001 0 00 00000000 0 00 00000000 0 00 00000000 01 1 12345678 00008001 1 0e 0
1 38afff00 0 00 00000000 0 00 00000000 0 00 00000000 03 1 0000ffff 0000ff00 1 0f 0
1 2030fff0 0 00 00000000 0 00 00000000 0 00 00000000 0a 3 11111111 fffffff0 1 10 0
1 2c518000 0 00 00000000 0 00 00000000 0 00 00000000 09 3 22222222 ffff8000 1 11 0
1 3c121234 0 00 00000000 0 00 00000000 0 00 00000000 02 1 00000000 12340000 1 12 0
1 34f300ff 0 00 00000000 0 00 00000000 0 00 00000000 02 1 00000007 000000ff 1 13 0
// Immediate shifts: sll 4, sra 31, srl 8.
1 0002a100 0 00 00000000 0 00 00000000 0 00 00000000 05 2 00000004 22222222 1 14 0
1 0003afc3 0 00 00000000 0 00 00000000 0 00 00000000 07 2 0000001f 80000003 1 15 0
1 0006b202 0 00 00000000 0 00 00000000 0 00 00000000 06 2 00000008 12345678 1 16 0
// Forwarding from ex and mem, and none for r0 or an immediate operand.
1 0022b820 1 01 aaaa0001 0 00 00000000 0 00 00000000 0a 3 aaaa0001 22222222 1 17 0
1 0022b820 0 00 00000000 1 01 bbbb0001 0 00 00000000 0a 3 bbbb0001 22222222 1 17 0
1 0022b820 1 01 cccc0001 1 01 dddd0001 0 00 00000000 0a 3 cccc0001 22222222 1 17 0
1 0022b820 1 02 ffff0002 1 01 eeee0001 0 00 00000000 0a 3 eeee0001 ffff0002 1 17 0
1 0002b820 1 00 99999999 1 00 88888888 0 00 00000000 0a 3 00000000 22222222 1 17 0
1 24380005 1 01 12121212 1 18 34343434 0 00 00000000 0b 3 12121212 00000005 1 18 0
// Writeback in the decode cycle, then a later read, then a write to r0.
1 0085c826 0 00 00000000 0 00 00000000 1 04 44440004 03 1 44440004 0000ffff 1 19 0
1 0080d023 0 00 00000000 0 00 00000000 0 00 00000000 0d 3 44440004 00000000 1 1a 0
1 0001d825 0 00 00000000 0 00 00000000 1 00 77777777 02 1 00000000 11111111 1 1b 0
// Invalid words back to back, then a valid one.
1 fc220000 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 0 00 1
1 00220001 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 0 00 1
1 00220060 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 0 00 1
1 00220100 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 0 00 1
1 00224024 0 00 00000000 0 00 00000000 0 00 00000000 01 1 11111111 22222222 1 08 0
